/* design/cnn_pkg.sv */
package cnn_pkg;

  //====================================================================
  // Sizes
  //====================================================================
  localparam int ADDR_W     = 19;                      // Byte address width
  localparam int K_SIZE     = 4;                       // Kernel side and dot product depth
  localparam int PIC_ROWS   = 8;
  localparam int PIC_COLS   = 8;
  localparam int OUT_ROWS   = PIC_ROWS - K_SIZE + 1;   // Window positions, stride 1
  localparam int OUT_COLS   = PIC_COLS - K_SIZE + 1;
  localparam int OUT_COUNT  = OUT_ROWS * OUT_COLS;     // Results per frame
  localparam int WR_BYTES   = 4;                       // Result bytes per write word
  localparam int WGT_BYTES  = K_SIZE * K_SIZE;
  localparam int BIAS_BYTES = 4;
  localparam int RD_DATA_W  = 128;

  //====================================================================
  // Datapath types
  //====================================================================
  typedef logic signed [31:0] acc_t;                   // Window accumulator
  typedef logic signed [7:0] wgt_byte_t;
  typedef wgt_byte_t [K_SIZE-1:0] wgt_row_t;           // One kernel row, lane 0 at byte 0
  typedef logic [$clog2(K_SIZE)-1:0] krow_t;           // Kernel row index

  //====================================================================
  // Memory and software ports
  //====================================================================
  typedef struct packed {
    logic              req;
    logic [ADDR_W-1:0] start_addr;
    logic [ADDR_W-1:0] size_bytes;
  } mem_rd_req_t;

  typedef struct packed {
    logic                 valid;                       // One cycle pulse
    logic [RD_DATA_W-1:0] data;
  } mem_rd_rsp_t;

  typedef struct packed {
    logic              req;
    logic [ADDR_W-1:0] start_addr;
    logic [ADDR_W-1:0] size_bytes;
    logic [31:0]       data;
  } mem_wr_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr_bias;
    logic [ADDR_W-1:0] addr_x;                         // Picture base
    logic [ADDR_W-1:0] addr_y;                         // Kernel base
    logic [ADDR_W-1:0] addr_z;                         // Result base
  } sw_cfg_t;

endpackage

/* design/cnn_ctrl.sv */
`timescale 1ns/1ps

module cnn_ctrl
  import cnn_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  sw_cfg_t     cfg,
  input  logic        go,
  input  logic        params_ready,
  input  logic        wr_pending,
  input  logic        frame_done,
  input  logic        pic_rd_rsp_valid,
  output logic        load_start,
  output krow_t       kernel_row,
  output mem_rd_req_t pic_rd_req,
  output logic        busy,
  output logic        done
);

  //====================================================================
  // Window FSM
  //====================================================================
  typedef enum logic [2:0] {
    IDLE,
    LOAD,                                              // Kernel and bias fetch
    READ,                                              // Picture read outstanding
    WAIT,                                              // Between picture reads
    DRAIN                                              // Last writes in flight
  } state_t;

  state_t                      state;
  krow_t                       k_cnt;
  logic [$clog2(OUT_COLS)-1:0] col_cnt;
  logic [$clog2(OUT_ROWS)-1:0] row_cnt;
  logic [ADDR_W-1:0]           row_base;               // addr_x plus row_cnt rows
  logic [ADDR_W-1:0]           pic_offset;
  logic [ADDR_W-1:0]           pic_addr;
  logic                        pic_req;
  logic                        last_k;
  logic                        last_col;
  logic                        last_row;

  assign last_k   = (k_cnt == K_SIZE - 1);
  assign last_col = (col_cnt == OUT_COLS - 1);
  assign last_row = (row_cnt == OUT_ROWS - 1);

  // Kernel row times picture width, plus the window column
  assign pic_offset = ADDR_W'(k_cnt) * ADDR_W'(PIC_COLS) + ADDR_W'(col_cnt);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= IDLE;
      pic_req  <= 1'b0;
      pic_addr <= '0;
      k_cnt    <= '0;
      col_cnt  <= '0;
      row_cnt  <= '0;
      row_base <= '0;
      done     <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        IDLE:
        begin
          if (go)
          begin
            state    <= LOAD;
            k_cnt    <= '0;
            col_cnt  <= '0;
            row_cnt  <= '0;
            row_base <= cfg.addr_x;
          end
        end
        LOAD:
        begin
          if (params_ready)
            state <= WAIT;
        end
        WAIT:
        begin
          if (!wr_pending)                             // Write back-pressure
          begin
            pic_req  <= 1'b1;
            pic_addr <= row_base + pic_offset;
            state    <= READ;
          end
        end
        READ:
        begin
          if (pic_rd_rsp_valid)
          begin
            pic_req <= 1'b0;
            state   <= WAIT;
            if (!last_k)
              k_cnt <= k_cnt + 1'b1;
            else
            begin
              k_cnt <= '0;
              if (!last_col)
                col_cnt <= col_cnt + 1'b1;
              else if (!last_row)
              begin
                col_cnt  <= '0;
                row_cnt  <= row_cnt + 1'b1;
                row_base <= row_base + ADDR_W'(PIC_COLS);
              end
              else
                state <= DRAIN;                        // Last window read done
            end
          end
        end
        DRAIN:
        begin
          if (frame_done)
          begin
            state <= IDLE;
            done  <= 1'b1;
          end
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  // Parameter fetch starts in the go cycle so its reads go out one cycle later
  assign load_start = (state == IDLE) && go;
  assign kernel_row = k_cnt;
  assign busy       = (state != IDLE);

  assign pic_rd_req = '{
    req:        pic_req,
    start_addr: pic_addr,
    size_bytes: ADDR_W'(K_SIZE)
  };

endmodule

/* design/cnn_param_load.sv */
`timescale 1ns/1ps

module cnn_param_load
  import cnn_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              load_start,
  input  logic [ADDR_W-1:0] addr_y,
  input  logic [ADDR_W-1:0] addr_bias,
  input  krow_t             kernel_row,
  output mem_rd_req_t       wgt_rd_req,
  output mem_rd_req_t       bias_rd_req,
  input  mem_rd_rsp_t       wgt_rd_rsp,
  input  mem_rd_rsp_t       bias_rd_rsp,
  output logic              params_ready,
  output wgt_row_t          row_wgt,
  output acc_t              bias
);

  wgt_row_t [K_SIZE-1:0] kernel_q;                     // Byte row*K_SIZE+col
  acc_t                  bias_q;
  logic                  wgt_req_q;
  logic                  bias_req_q;
  logic                  wgt_got_q;
  logic                  bias_got_q;

  //====================================================================
  // One fetch of each per frame
  //====================================================================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wgt_req_q  <= 1'b0;
      bias_req_q <= 1'b0;
      wgt_got_q  <= 1'b0;
      bias_got_q <= 1'b0;
    end
    else if (load_start)
    begin
      wgt_req_q  <= 1'b1;
      bias_req_q <= 1'b1;
      wgt_got_q  <= 1'b0;                              // Drop last frame's ready
      bias_got_q <= 1'b0;
    end
    else
    begin
      if (wgt_req_q && wgt_rd_rsp.valid)
      begin
        wgt_req_q <= 1'b0;
        wgt_got_q <= 1'b1;
      end
      if (bias_req_q && bias_rd_rsp.valid)
      begin
        bias_req_q <= 1'b0;
        bias_got_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (wgt_req_q && wgt_rd_rsp.valid)
      kernel_q <= wgt_rd_rsp.data[WGT_BYTES*8-1:0];
    if (bias_req_q && bias_rd_rsp.valid)
      bias_q <= bias_rd_rsp.data[BIAS_BYTES*8-1:0];   // Little-endian, signed
  end

  assign wgt_rd_req = '{
    req:        wgt_req_q,
    start_addr: addr_y,
    size_bytes: ADDR_W'(WGT_BYTES)
  };

  assign bias_rd_req = '{
    req:        bias_req_q,
    start_addr: addr_bias,
    size_bytes: ADDR_W'(BIAS_BYTES)
  };

  assign params_ready = wgt_got_q && bias_got_q;
  assign row_wgt      = kernel_q[kernel_row];          // Row matching the picture read
  assign bias         = bias_q;

endmodule

/* design/cnn_mac.sv */
`timescale 1ns/1ps

module cnn_mac
  import cnn_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  mem_rd_rsp_t pic_rd_rsp,
  input  krow_t       kernel_row,
  input  wgt_row_t    row_wgt,
  input  acc_t        bias,
  output logic        res_valid,
  output logic [7:0]  res_byte
);

  acc_t dot;                                           // Row dot product
  acc_t acc_q;                                         // Window sum
  acc_t sum_q;                                         // Window sum plus bias
  logic row_last_q;

  //====================================================================
  // Row dot product, unsigned picture by signed kernel
  //====================================================================
  always_comb
  begin
    dot = '0;
    for (int i = 0; i < K_SIZE; i++)
      dot = dot + $signed({1'b0, pic_rd_rsp.data[8*i +: 8]}) * row_wgt[i];
  end

  always_ff @(posedge clk)
  begin
    if (pic_rd_rsp.valid)
    begin
      if (kernel_row == '0)
        acc_q <= dot;                                  // First row starts a new window
      else
        acc_q <= acc_q + dot;
    end
    if (row_last_q)
      sum_q <= acc_q + bias;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      row_last_q <= 1'b0;
      res_valid  <= 1'b0;
    end
    else
    begin
      row_last_q <= pic_rd_rsp.valid && (kernel_row == K_SIZE - 1);
      res_valid  <= row_last_q;                        // Two cycles after the last row
    end
  end

  // Clamp activation to 0..255
  always_comb
  begin
    if (sum_q < 0)
      res_byte = 8'd0;
    else if (sum_q > 255)
      res_byte = 8'hff;
    else
      res_byte = sum_q[7:0];
  end

endmodule

/* design/cnn_wr_packer.sv */
`timescale 1ns/1ps

module cnn_wr_packer
  import cnn_pkg::*;
(
  input  logic              clk,
  input  logic              rst_n,
  input  logic              res_valid,
  input  logic [7:0]        res_byte,
  input  logic [ADDR_W-1:0] addr_z,
  output mem_wr_req_t       wr_req,
  input  logic              wr_ack,
  output logic              wr_pending,
  output logic              frame_done
);

  logic [WR_BYTES-1:0][7:0]       word_q;              // Bytes still being collected
  logic [WR_BYTES-1:0][7:0]       word_nx;
  logic [$clog2(WR_BYTES)-1:0]    lane;
  logic [$clog2(OUT_COUNT)-1:0]   res_cnt;
  logic [$clog2(OUT_COUNT)-1:0]   word_idx;            // Words acked this frame
  logic                           last_res;
  logic                           word_full;
  logic                           last_word;
  logic                           wr_req_q;
  logic [ADDR_W-1:0]              wr_addr;
  logic [ADDR_W-1:0]              wr_size;
  logic [31:0]                    wr_data;

  always_comb
  begin
    word_nx       = word_q;
    word_nx[lane] = res_byte;
  end

  assign word_full = (lane == WR_BYTES - 1);
  assign last_res  = (res_cnt == OUT_COUNT - 1);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      word_q    <= '0;
      lane      <= '0;
      res_cnt   <= '0;
      word_idx  <= '0;
      last_word <= 1'b0;
      wr_req_q  <= 1'b0;
    end
    else
    begin
      if (res_valid)
      begin
        res_cnt <= last_res ? '0 : res_cnt + 1'b1;
        if (word_full || last_res)
        begin
          word_q    <= '0;                             // Partial word keeps zero lanes
          lane      <= '0;
          wr_req_q  <= 1'b1;
          last_word <= last_res;
        end
        else
        begin
          word_q <= word_nx;
          lane   <= lane + 1'b1;
        end
      end
      if (wr_req_q && wr_ack)
      begin
        wr_req_q  <= 1'b0;
        word_idx  <= last_word ? '0 : word_idx + 1'b1;
        last_word <= 1'b0;
      end
    end
  end

  // Write payload, held until ack
  always_ff @(posedge clk)
  begin
    if (res_valid && (word_full || last_res))
    begin
      wr_data <= word_nx;
      wr_size <= ADDR_W'(lane) + ADDR_W'(1);
      wr_addr <= addr_z + (ADDR_W'(word_idx) << 2);
    end
  end

  assign wr_req = '{
    req:        wr_req_q,
    start_addr: wr_addr,
    size_bytes: wr_size,
    data:       wr_data
  };

  assign wr_pending = wr_req_q;
  assign frame_done = wr_req_q && wr_ack && last_word;

endmodule

/* design/cnn_top.sv */
`timescale 1ns/1ps

module cnn_top
  import cnn_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  sw_cfg_t     cfg,
  input  logic        go,
  output logic        busy,
  output logic        done,
  output mem_rd_req_t pic_rd_req,
  output mem_rd_req_t wgt_rd_req,
  output mem_rd_req_t bias_rd_req,
  input  mem_rd_rsp_t pic_rd_rsp,
  input  mem_rd_rsp_t wgt_rd_rsp,
  input  mem_rd_rsp_t bias_rd_rsp,
  output mem_wr_req_t wr_req,
  input  logic        wr_ack
);

  logic       load_start;
  logic       params_ready;
  logic       wr_pending;
  logic       frame_done;
  krow_t      kernel_row;                              // Row of the picture read in flight
  wgt_row_t   row_wgt;
  acc_t       bias;
  logic       res_valid;
  logic [7:0] res_byte;

  cnn_ctrl i_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .cfg              (cfg),
    .go               (go),
    .params_ready     (params_ready),
    .wr_pending       (wr_pending),
    .frame_done       (frame_done),
    .pic_rd_rsp_valid (pic_rd_rsp.valid),
    .load_start       (load_start),
    .kernel_row       (kernel_row),
    .pic_rd_req       (pic_rd_req),
    .busy             (busy),
    .done             (done)
  );

  cnn_param_load i_param_load (
    .clk          (clk),
    .rst_n        (rst_n),
    .load_start   (load_start),
    .addr_y       (cfg.addr_y),
    .addr_bias    (cfg.addr_bias),
    .kernel_row   (kernel_row),
    .wgt_rd_req   (wgt_rd_req),
    .bias_rd_req  (bias_rd_req),
    .wgt_rd_rsp   (wgt_rd_rsp),
    .bias_rd_rsp  (bias_rd_rsp),
    .params_ready (params_ready),
    .row_wgt      (row_wgt),
    .bias         (bias)
  );

  cnn_mac i_mac (
    .clk        (clk),
    .rst_n      (rst_n),
    .pic_rd_rsp (pic_rd_rsp),
    .kernel_row (kernel_row),
    .row_wgt    (row_wgt),
    .bias       (bias),
    .res_valid  (res_valid),
    .res_byte   (res_byte)
  );

  cnn_wr_packer i_wr_packer (
    .clk        (clk),
    .rst_n      (rst_n),
    .res_valid  (res_valid),
    .res_byte   (res_byte),
    .addr_z     (cfg.addr_z),
    .wr_req     (wr_req),
    .wr_ack     (wr_ack),
    .wr_pending (wr_pending),
    .frame_done (frame_done)
  );

endmodule

/* test/cnn_tb_model.svh */
`ifndef CNN_TB_MODEL_SVH
`define CNN_TB_MODEL_SVH

  //====================================================================
  // Random numbers
  //====================================================================
  logic [31:0] rng_state = 32'd16908;

  function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic int rand_delay();
    return int'(xorshift32() % 32'd8);                 // 0 to 7 cycles
  endfunction

  //====================================================================
  // Reference convolution
  //====================================================================
  // Picture offset of read idx, kernel row fastest, then column, then row
  function automatic int pic_offset(input int idx);
    int k;
    int win;
    k   = idx % K_SIZE;
    win = idx / K_SIZE;
    return ((win / OUT_COLS) + k) * PIC_COLS + (win % OUT_COLS);
  endfunction

  function automatic logic [RD_DATA_W-1:0] pic_row_word(input int idx);
    logic [RD_DATA_W-1:0] w;
    w = '0;
    for (int i = 0; i < K_SIZE; i++)
      w[8*i +: 8] = pic_img[pic_offset(idx) + i];
    return w;
  endfunction

  function automatic logic [RD_DATA_W-1:0] kernel_word();
    logic [RD_DATA_W-1:0] w;
    w = '0;
    for (int i = 0; i < WGT_BYTES; i++)
      w[8*i +: 8] = kern[i];                           // Byte row*K_SIZE+col
    return w;
  endfunction

  function automatic void build_expected();
    int sum;
    int n;
    logic [7:0] res;
    for (int w = 0; w < N_WORDS; w++)
    begin
      exp_word[w] = '0;
      exp_size[w] = '0;
    end
    for (int r = 0; r < OUT_ROWS; r++)
      for (int c = 0; c < OUT_COLS; c++)
      begin
        sum = bias_val;
        for (int k = 0; k < K_SIZE; k++)
          for (int j = 0; j < K_SIZE; j++)
            sum = sum + int'(pic_img[(r + k) * PIC_COLS + c + j]) * int'(kern[k * K_SIZE + j]);
        res = (sum < 0) ? 8'd0 : (sum > 255) ? 8'd255 : sum[7:0];  // Clamp to 0..255
        n = r * OUT_COLS + c;
        exp_word[n / WR_BYTES][8 * (n % WR_BYTES) +: 8] = res;
        exp_size[n / WR_BYTES] = ADDR_W'(n % WR_BYTES + 1);
      end
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected)
    begin
      $display("FAILED at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
      stop_run("Value mismatch");
    end
  endtask

`endif

/* test/cnn_tb.sv */
`timescale 1ns/1ps

module cnn_tb
  import cnn_pkg::*;
();

  localparam int N_FRAMES = 3;
  localparam int N_READS  = OUT_COUNT * K_SIZE;
  localparam int N_WORDS  = (OUT_COUNT + WR_BYTES - 1) / WR_BYTES;
  localparam int WATCHDOG_CYCLES = N_FRAMES * (N_READS + N_WORDS) * 10 + 2000;

  logic        clk = 1'b0;
  logic        rst_n;
  sw_cfg_t     cfg;
  sw_cfg_t     frame_cfg;                              // Addresses of the running frame
  logic        go;
  logic        busy;
  logic        done;
  mem_rd_req_t pic_rd_req;
  mem_rd_req_t wgt_rd_req;
  mem_rd_req_t bias_rd_req;
  mem_rd_rsp_t pic_rd_rsp;
  mem_rd_rsp_t wgt_rd_rsp;
  mem_rd_rsp_t bias_rd_rsp;
  mem_wr_req_t wr_req;
  logic        wr_ack;

  logic [7:0]        pic_img [PIC_ROWS*PIC_COLS];
  logic signed [7:0] kern [WGT_BYTES];
  acc_t              bias_val;
  logic [31:0]       exp_word [N_WORDS];
  logic [ADDR_W-1:0] exp_size [N_WORDS];
  int                pic_cnt;
  int                wgt_cnt;
  int                bias_cnt;
  int                wr_cnt;
  logic              wr_req_prev = 1'b0;               // Write request in the previous cycle

`include "cnn_tb_model.svh"

  always #4 clk = ~clk;

  cnn_top i_cnn_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg         (cfg),
    .go          (go),
    .busy        (busy),
    .done        (done),
    .pic_rd_req  (pic_rd_req),
    .wgt_rd_req  (wgt_rd_req),
    .bias_rd_req (bias_rd_req),
    .pic_rd_rsp  (pic_rd_rsp),
    .wgt_rd_rsp  (wgt_rd_rsp),
    .bias_rd_rsp (bias_rd_rsp),
    .wr_req      (wr_req),
    .wr_ack      (wr_ack)
  );

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  // New addresses and data for the next frame
  task automatic new_frame();
    logic [31:0] r;
    frame_cfg.addr_x    = ADDR_W'(xorshift32() & 32'h3ffff);
    frame_cfg.addr_y    = ADDR_W'(xorshift32());
    frame_cfg.addr_bias = ADDR_W'(xorshift32());
    frame_cfg.addr_z    = ADDR_W'(xorshift32() & 32'h3ffff);
    for (int i = 0; i < PIC_ROWS * PIC_COLS; i++)
      pic_img[i] = 8'(xorshift32());
    for (int i = 0; i < WGT_BYTES; i++)
    begin
      r = xorshift32();
      kern[i] = $signed(8'(r % 32'd5)) - 8'sd2;      // -2..2 keeps some sums unclamped
    end
    bias_val = acc_t'(xorshift32() % 32'd4001) - 32'sd2000;
    pic_cnt  = 0;
    wgt_cnt  = 0;
    bias_cnt = 0;
    wr_cnt   = 0;
    build_expected();
  endtask

  //====================================================================
  // Memory responders
  //====================================================================
  initial
  begin
    forever
    begin
      @(posedge clk);
      if (pic_rd_req.req)
      begin
        if (pic_cnt >= N_READS)
          stop_run("Picture read after the last window");
        if (wgt_cnt != 1 || bias_cnt != 1)
          stop_run("Picture read before kernel and bias were loaded");
        if (wr_req_prev)
          stop_run("Picture read started while a write was pending");
        check_value("pic_rd_req.start_addr",
                    64'(frame_cfg.addr_x + ADDR_W'(pic_offset(pic_cnt))),
                    64'(pic_rd_req.start_addr));
        check_value("pic_rd_req.size_bytes", 64'(K_SIZE), 64'(pic_rd_req.size_bytes));
        repeat (rand_delay())
        begin
          @(posedge clk);
          check_value("pic_rd_req.req", 64'(1), 64'(pic_rd_req.req));  // Held until valid
        end
        pic_rd_rsp.valid <= 1'b1;
        pic_rd_rsp.data  <= pic_row_word(pic_cnt);
        @(posedge clk);
        pic_rd_rsp.valid <= 1'b0;
        pic_cnt = pic_cnt + 1;
      end
      wr_req_prev = wr_req.req;                        // Back-pressure seen by the next read
    end
  end

  initial
  begin
    forever
    begin
      @(posedge clk);
      if (wgt_rd_req.req)
      begin
        if (wgt_cnt != 0)
          stop_run("Second weight read in one frame");
        check_value("wgt_rd_req.start_addr", 64'(frame_cfg.addr_y),
                    64'(wgt_rd_req.start_addr));
        check_value("wgt_rd_req.size_bytes", 64'(WGT_BYTES), 64'(wgt_rd_req.size_bytes));
        repeat (rand_delay()) @(posedge clk);
        wgt_rd_rsp.valid <= 1'b1;
        wgt_rd_rsp.data  <= kernel_word();
        @(posedge clk);
        wgt_rd_rsp.valid <= 1'b0;
        wgt_cnt = wgt_cnt + 1;
      end
    end
  end

  initial
  begin
    forever
    begin
      @(posedge clk);
      if (bias_rd_req.req)
      begin
        if (bias_cnt != 0)
          stop_run("Second bias read in one frame");
        check_value("bias_rd_req.start_addr", 64'(frame_cfg.addr_bias),
                    64'(bias_rd_req.start_addr));
        check_value("bias_rd_req.size_bytes", 64'(BIAS_BYTES), 64'(bias_rd_req.size_bytes));
        repeat (rand_delay()) @(posedge clk);
        bias_rd_rsp.valid <= 1'b1;
        bias_rd_rsp.data  <= RD_DATA_W'(unsigned'(bias_val));  // Little-endian in low bytes
        @(posedge clk);
        bias_rd_rsp.valid <= 1'b0;
        bias_cnt = bias_cnt + 1;
      end
    end
  end

  initial
  begin
    forever
    begin
      @(posedge clk);
      if (wr_req.req)
      begin
        if (wr_cnt >= N_WORDS)
          stop_run("Write request beyond the last result word");
        check_value("wr_req.start_addr", 64'(frame_cfg.addr_z + ADDR_W'(4 * wr_cnt)),
                    64'(wr_req.start_addr));
        check_value("wr_req.size_bytes", 64'(exp_size[wr_cnt]), 64'(wr_req.size_bytes));
        check_value("wr_req.data", 64'(exp_word[wr_cnt]), 64'(wr_req.data));
        repeat (rand_delay())
        begin
          @(posedge clk);
          check_value("wr_req.req", 64'(1), 64'(wr_req.req));
          check_value("wr_req.data", 64'(exp_word[wr_cnt]), 64'(wr_req.data));
        end
        wr_ack <= 1'b1;
        @(posedge clk);
        wr_ack <= 1'b0;
        wr_cnt = wr_cnt + 1;
      end
    end
  end

  //====================================================================
  // Watchdog and frame sequence
  //====================================================================
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_run("Timeout: the engine did not finish all frames in time");
  end

  initial
  begin
    rst_n       = 1'b0;
    go          = 1'b0;
    cfg         = '0;
    frame_cfg   = '0;
    pic_rd_rsp  = '0;
    wgt_rd_rsp  = '0;
    bias_rd_rsp = '0;
    wr_ack      = 1'b0;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    check_value("busy", 64'(0), 64'(busy));
    check_value("done", 64'(0), 64'(done));
    check_value("pic_rd_req.req", 64'(0), 64'(pic_rd_req.req));
    check_value("wgt_rd_req.req", 64'(0), 64'(wgt_rd_req.req));
    check_value("bias_rd_req.req", 64'(0), 64'(bias_rd_req.req));
    check_value("wr_req.req", 64'(0), 64'(wr_req.req));
    for (int f = 0; f < N_FRAMES; f++)
    begin
      new_frame();
      @(posedge clk);
      cfg <= frame_cfg;                                // Stable until the next go
      go  <= 1'b1;
      @(posedge clk);
      go <= 1'b0;
      do
      begin
        @(posedge clk);
        if (!done)
          check_value("busy", 64'(1), 64'(busy));
      end
      while (!done);
      check_value("busy", 64'(0), 64'(busy));          // Falls with done
      check_value("pic reads", 64'(N_READS), 64'(pic_cnt));
      check_value("writes", 64'(N_WORDS), 64'(wr_cnt));
      check_value("weight reads", 64'(1), 64'(wgt_cnt));
      check_value("bias reads", 64'(1), 64'(bias_cnt));
      @(posedge clk);
      check_value("done", 64'(0), 64'(done));          // Single cycle pulse
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

/* sources.f */
+incdir+test
design/cnn_pkg.sv
design/cnn_ctrl.sv
design/cnn_param_load.sv
design/cnn_mac.sv
design/cnn_wr_packer.sv
design/cnn_top.sv
test/cnn_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -f sources.f --top-module cnn_tb \
  --Mdir obj_dir -o cnn_sim > build.log 2>&1 &&
./obj_dir/cnn_sim > sim.log 2>&1

grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
